/* rtl/id_scratch_register.sv */
/*
 Identity block. The chip id is read-only. The scratch byte is written by
 every data byte, so each return shows the byte written just before it.
*/
`timescale 1ns/100ps

module id_scratch_register import spi_bus_pkg::*, register_map_pkg::*; (
    input  logic                  system_clock,
    input  logic                  arst_n,
    input  logic                  enable,
    input  logic [byte_width-1:0] address,
    input  spi_byte_t             copi,
    output spi_byte_t             data_return
);

    logic [byte_width-1:0] scratch;
    logic                  scratch_write;

    assign scratch_write = enable && copi.valid && (address == scratch_address);

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            scratch     <= scratch_reset_value;
            data_return <= '0;
        end else begin
            if (scratch_write) begin
                scratch <= copi.data;
            end
            data_return.valid <= enable;
            if (address == chip_id_address) begin
                data_return.data <= chip_id_value;
            end else if (scratch_write) begin
                // show the new value one cycle after the strobe
                data_return.data <= copi.data;
            end else begin
                data_return.data <= scratch;
            end
        end
    end

endmodule

/* rtl/register_map_pkg.sv */
/*
 Register map of the subsystem. Addresses outside this map select no block,
 and such a transaction reads back 0x00.
*/

package register_map_pkg;

    // identity block
    localparam logic [7:0] chip_id_address     = 8'hDB;
    localparam logic [7:0] scratch_address     = 8'hDC;
    localparam logic [7:0] chip_id_value       = 8'h0A;
    localparam logic [7:0] scratch_reset_value = 8'h00;

    // version block
    localparam logic [7:0] version_address = 8'hB5;
    localparam int         version_length  = 8;

    // first character in the top byte
    localparam logic [8*version_length-1:0] version_string = "v0.1-dev";

endpackage

/* rtl/spi_bus_pkg.sv */
/*
 Byte-level types shared by the SPI front end, the selector and the
 register blocks. Every strobe is a single-cycle pulse with no back-pressure.
*/

package spi_bus_pkg;

    // bits per SPI transfer unit
    localparam int byte_width = 8;

    // one byte on the internal bus, valid is a one-cycle strobe
    // except for the register returns, where it follows the enable
    typedef struct packed {
        logic                  valid;
        logic [byte_width-1:0] data;
    } spi_byte_t;

endpackage

/* rtl/spi_peripheral.sv */
/*
 SPI mode 0 peripheral, MSB first, pins sampled in the system_clock domain.
 The host must hold each SPI half-period for at least 8 system_clock cycles.
 The first byte after select falls is strobed as address, later ones as data.
*/
`timescale 1ns/100ps

module spi_peripheral import spi_bus_pkg::*; (
    input  logic      system_clock,
    input  logic      arst_n,
    input  logic      spi_select,
    input  logic      spi_clock,
    input  logic      spi_copi,
    output logic      spi_cipo,
    output spi_byte_t address,
    output spi_byte_t copi,
    output logic      select_active,
    input  spi_byte_t cipo
);

    // two flop synchronizers, bit 1 is the settled value
    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] copi_sync;
    logic       clock_last;
    logic       clock_rise;
    logic       clock_fall;

    logic [$clog2(byte_width)-1:0] bit_count;
    logic                          first_byte;
    logic [byte_width-1:0]         shift_in;
    logic [byte_width-1:0]         byte_in;
    logic [byte_width-1:0]         shift_out;

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            select_sync <= '1;
            clock_sync  <= '0;
            copi_sync   <= '0;
            clock_last  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync  <= {clock_sync[0], spi_clock};
            copi_sync   <= {copi_sync[0], spi_copi};
            clock_last  <= clock_sync[1];
        end
    end

    assign select_active = ~select_sync[1];

    // edges only count inside a transaction
    assign clock_rise = clock_sync[1] & ~clock_last & select_active;
    assign clock_fall = ~clock_sync[1] & clock_last & select_active;

    // byte as it stands with the bit sampled on this edge
    assign byte_in = {shift_in[byte_width-2:0], copi_sync[1]};

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            bit_count  <= '0;
            first_byte <= 1'b1;
            shift_in   <= '0;
            address    <= '0;
            copi       <= '0;
        end else begin
            address.valid <= 1'b0;
            copi.valid    <= 1'b0;
            if (!select_active) begin
                bit_count  <= '0;
                first_byte <= 1'b1;
            end else if (clock_rise) begin
                bit_count <= bit_count + 1'b1;
                shift_in  <= byte_in;
                // eighth bit closes the byte
                if (bit_count == '1) begin
                    first_byte <= 1'b0;
                    if (first_byte) begin
                        address <= '{valid: 1'b1, data: byte_in};
                    end else begin
                        copi <= '{valid: 1'b1, data: byte_in};
                    end
                end
            end
        end
    end

    // return path, loaded on the falling edge right after a full byte
    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            shift_out <= '0;
        end else if (!select_active) begin
            shift_out <= '0;
        end else if (clock_fall) begin
            if (bit_count == '0) begin
                shift_out <= cipo.valid ? cipo.data : '0;
            end else begin
                shift_out <= {shift_out[byte_width-2:0], 1'b0};
            end
        end
    end

    assign spi_cipo = shift_out[byte_width-1];

endmodule

/* rtl/spi_subsystem_top.sv */
/*
 SPI register subsystem, mode 0 peripheral with two register blocks.
 All logic runs on system_clock; the SPI pins are synchronized at the edge.
*/
`timescale 1ns/100ps

module spi_subsystem_top import spi_bus_pkg::*; (
    input  logic system_clock,
    input  logic arst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_copi,
    output logic spi_cipo
);

    spi_byte_t             address;
    spi_byte_t             copi;
    spi_byte_t             cipo;
    spi_byte_t             id_return;
    spi_byte_t             version_return;
    logic                  select_active;
    logic                  id_enable;
    logic                  version_enable;
    logic [byte_width-1:0] latched_address;

    spi_peripheral i_spi_peripheral (
        .system_clock  (system_clock),
        .arst_n        (arst_n),
        .spi_select    (spi_select),
        .spi_clock     (spi_clock),
        .spi_copi      (spi_copi),
        .spi_cipo      (spi_cipo),
        .address       (address),
        .copi          (copi),
        .select_active (select_active),
        .cipo          (cipo)
    );

    subperipheral_selector i_subperipheral_selector (
        .system_clock    (system_clock),
        .arst_n          (arst_n),
        .address         (address),
        .select_active   (select_active),
        .id_return       (id_return),
        .version_return  (version_return),
        .id_enable       (id_enable),
        .version_enable  (version_enable),
        .latched_address (latched_address),
        .cipo            (cipo)
    );

    id_scratch_register i_id_scratch_register (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .enable       (id_enable),
        .address      (latched_address),
        .copi         (copi),
        .data_return  (id_return)
    );

    version_string_register i_version_string_register (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .enable       (version_enable),
        .copi         (copi),
        .data_return  (version_return)
    );

endmodule

/* rtl/subperipheral_selector.sv */
/*
 Address decoder and return mux. Exactly one block is enabled per known
 address, none for an unknown one. Enables drop once select is released.
*/
`timescale 1ns/100ps

module subperipheral_selector import spi_bus_pkg::*, register_map_pkg::*; (
    input  logic                  system_clock,
    input  logic                  arst_n,
    input  spi_byte_t             address,
    input  logic                  select_active,
    input  spi_byte_t             id_return,
    input  spi_byte_t             version_return,
    output logic                  id_enable,
    output logic                  version_enable,
    output logic [byte_width-1:0] latched_address,
    output spi_byte_t             cipo
);

    logic id_hit;
    logic version_hit;

    assign id_hit      = (address.data == chip_id_address) ||
                         (address.data == scratch_address);
    assign version_hit = (address.data == version_address);

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            id_enable      <= 1'b0;
            version_enable <= 1'b0;
        end else if (!select_active) begin
            id_enable      <= 1'b0;
            version_enable <= 1'b0;
        end else if (address.valid) begin
            id_enable      <= id_hit;
            version_enable <= version_hit;
        end
    end

    always_ff @(posedge system_clock) begin
        if (address.valid) begin
            latched_address <= address.data;
        end
    end

    // nothing enabled means an invalid return, shifted out as 0x00
    always_comb begin
        if (id_enable) begin
            cipo = id_return;
        end else if (version_enable) begin
            cipo = version_return;
        end else begin
            cipo = '0;
        end
    end

endmodule

/* rtl/version_string_register.sv */
/*
 Version block. Streams the version string one character per data byte,
 wraps after the last character and restarts with each transaction.
*/
`timescale 1ns/100ps

module version_string_register import spi_bus_pkg::*, register_map_pkg::*; (
    input  logic      system_clock,
    input  logic      arst_n,
    input  logic      enable,
    input  spi_byte_t copi,
    output spi_byte_t data_return
);

    logic [$clog2(version_length)-1:0] pointer;
    logic [$clog2(version_length)-1:0] pointer_next;
    logic [byte_width-1:0]             character;

    always_comb begin
        pointer_next = pointer;
        if (!enable) begin
            pointer_next = '0;
        end else if (copi.valid) begin
            // wrap back to the first character
            if (int'(pointer) == version_length - 1) begin
                pointer_next = '0;
            end else begin
                pointer_next = pointer + 1'b1;
            end
        end
    end

    // character 0 sits in the top byte of the string
    assign character =
        version_string[(version_length - 1 - int'(pointer_next)) * byte_width +: byte_width];

    always_ff @(posedge system_clock or negedge arst_n) begin
        if (!arst_n) begin
            pointer     <= '0;
            data_return <= '0;
        end else begin
            pointer           <= pointer_next;
            data_return.valid <= enable;
            data_return.data  <= character;
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module spi_subsystem_tb -f src.f \
    && ./obj_dir/Vspi_subsystem_tb | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }

/* src.f */
rtl/spi_bus_pkg.sv
rtl/register_map_pkg.sv
rtl/spi_peripheral.sv
rtl/id_scratch_register.sv
rtl/version_string_register.sv
rtl/subperipheral_selector.sv
rtl/spi_subsystem_top.sv
verification/spi_subsystem_props.sv
verification/spi_subsystem_tb.sv

/* verification/spi_subsystem_props.sv */
/*
 Concurrent checks on the address decoder and return mux.
 Bound into every subperipheral_selector, inactive while arst_n is low.
*/
`timescale 1ns/100ps

module spi_subsystem_props import spi_bus_pkg::*; (
    input logic      system_clock,
    input logic      arst_n,
    input logic      select_active,
    input logic      id_enable,
    input logic      version_enable,
    input spi_byte_t cipo
);

    // at most one register block owns the return path
    one_enable: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        !(id_enable && version_enable)
    ) else $error("id and version blocks enabled together");

    // released select clears both enables on the next edge
    enables_cleared: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        !select_active |=> (!id_enable && !version_enable)
    ) else $error("enable still high after select was released");

    idle_return: assert property (
        @(posedge system_clock) disable iff (!arst_n)
        cipo.valid |-> (id_enable || version_enable)
    ) else $error("return byte valid with no block enabled");

endmodule

bind subperipheral_selector spi_subsystem_props i_props (
    .system_clock   (system_clock),
    .arst_n         (arst_n),
    .select_active  (select_active),
    .id_enable      (id_enable),
    .version_enable (version_enable),
    .cipo           (cipo)
);

/* verification/spi_subsystem_tb.sv */
/*
 Testbench for the SPI register subsystem, run from the project root.
 Transactions and expected return bytes come from verification/spi_vectors.txt.
 The host bit-bangs SPI mode 0 with 8 system cycles per half-period.
*/
`timescale 1ns/100ps

module spi_subsystem_tb;

    localparam int half_period      = 8;
    localparam int reset_cycles     = 2;
    localparam int max_transactions = 32;
    localparam int max_bytes        = 16;

    logic system_clock;
    logic arst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_copi;
    logic spi_cipo;

    // transactions as read from the vectors file
    logic [7:0] vector_address [max_transactions];
    int         vector_count   [max_transactions];
    logic [7:0] sent_bytes     [max_transactions][max_bytes];
    logic [7:0] expected_bytes [max_transactions][max_bytes];
    int         transaction_total = 0;
    int         longest_count     = 0;

    int     error_count = 0;
    int     byte_total  = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    integer seed;

    spi_subsystem_top i_dut (
        .system_clock (system_clock),
        .arst_n       (arst_n),
        .spi_select   (spi_select),
        .spi_clock    (spi_clock),
        .spi_copi     (spi_copi),
        .spi_cipo     (spi_cipo)
    );

    initial system_clock = 1'b0;
    always #20 system_clock = ~system_clock;

    always @(posedge system_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the transactions did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic wait_cycles(input int count);
        repeat (count) @(posedge system_clock);
    endtask

    task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t ns: %s expected 0x%h, got 0x%h",
                     $time, what, expected, actual);
            error_count++;
        end
    endtask

    function automatic bit load_vectors();
        int               fd;
        int               code;
        int               count;
        logic [7:0]       value;
        logic [8*100-1:0] skipped;
        fd = $fopen("verification/spi_vectors.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd) && transaction_total < max_transactions) begin
            code = $fscanf(fd, "%h", value);
            if (code == 1) begin
                vector_address[transaction_total] = value;
                code = $fscanf(fd, "%d", count);
                vector_count[transaction_total] = count;
                for (int b = 0; b < count; b++) begin
                    code = $fscanf(fd, "%h", value);
                    sent_bytes[transaction_total][b] = value;
                end
                for (int b = 0; b < count; b++) begin
                    code = $fscanf(fd, "%h", value);
                    expected_bytes[transaction_total][b] = value;
                end
                if (count > longest_count) begin
                    longest_count = count;
                end
                transaction_total++;
            end else if (code == 0) begin
                // comment line, drop the rest of it
                code = $fgets(skipped, fd);
            end else begin
                break;
            end
        end
        $fclose(fd);
        return transaction_total > 0;
    endfunction

    // mode 0, copi changes with the falling edge, cipo is taken at the rising one
    task automatic transfer_byte(input logic [7:0] out_byte, output logic [7:0] in_byte);
        for (int i = 7; i >= 0; i--) begin
            spi_copi <= out_byte[i];
            wait_cycles(half_period);
            in_byte[i] = spi_cipo;
            spi_clock <= 1'b1;
            wait_cycles(half_period);
            spi_clock <= 1'b0;
        end
    endtask

    task automatic run_transaction(input int index);
        logic [7:0] returned;
        int         errors_before;
        errors_before = error_count;
        spi_select <= 1'b0;
        // nothing useful comes back during the address byte
        transfer_byte(vector_address[index], returned);
        for (int b = 0; b < vector_count[index]; b++) begin
            transfer_byte(sent_bytes[index][b], returned);
            check_value(returned, expected_bytes[index][b],
                        $sformatf("transaction %0d byte %0d", index, b));
            byte_total++;
        end
        wait_cycles(half_period);
        spi_select <= 1'b1;
        spi_copi   <= 1'b0;
        $display("transaction %0d, address 0x%h, %0d data bytes: %s", index,
                 vector_address[index], vector_count[index],
                 (error_count == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        seed = 78911;
        arst_n     <= 1'b0;
        spi_select <= 1'b1;
        spi_clock  <= 1'b0;
        spi_copi   <= 1'b0;
        if (!load_vectors()) begin
            $display("error: no transactions could be read from verification/spi_vectors.txt");
            error_count++;
        end else begin
            // each byte takes 128 cycles, the rest covers the gaps
            cycle_limit = reset_cycles + 200 + transaction_total * (longest_count + 1) * 160;
            wait_cycles(reset_cycles);
            arst_n <= 1'b1;
            wait_cycles(half_period);
            for (int t = 0; t < transaction_total; t++) begin
                run_transaction(t);
                wait_cycles(4 + ({$random(seed)} % 12));
            end
        end
        $display("summary: %0d transactions, %0d bytes checked, %0d errors",
                 transaction_total, byte_total, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verification/spi_vectors.txt */
# address, data byte count, bytes sent, then bytes expected back (all hex but the count)
# every byte sent to the scratch address is written, so reads resend the current value
dc 1 00 00
db 3 11 22 33 0a 0a 0a
dc 2 a5 3c 00 a5
dc 1 3c 3c
b5 8 00 00 00 00 00 00 00 00 76 30 2e 31 2d 64 65 76
b5 10 00 00 00 00 00 00 00 00 00 00 76 30 2e 31 2d 64 65 76 76 30
b5 2 00 00 76 30
5a 3 ff ff ff 00 00 00
dc 1 3c 3c
db 1 ff 0a
b5 3 11 22 33 76 30 2e
00 2 12 34 00 00
dc 3 01 02 03 3c 01 02
b6 1 55 00
dc 1 03 03
db 2 00 00 0a 0a
